//--- Makefile
TOOL := verilator
TOP := tbLspc2
FILELIST := verilog.f
FLAGS := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJDIR := obj_dir
SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run lint clean

all: run

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- cpuPortDecode.sv
// CPU port stage
// Forwards commands to the VRAM side and returns read data two cycles
// after the read strobe
`timescale 1ns/1ns
`default_nettype none
`include "lspc_defines.svh"

module cpuPortDecode
	import lspcRegPkg::*, lspcVideoPkg::*;
(
	input wire logic clk24M,
	input wire logic reset,
	input wire cpuBus_t cpu,
	input wire videoStatus_t status,
	input wire logic [15:0] vramRead,
	input wire logic [15:0] modulo,
	output logic [15:0] rdData,
	output logic rdValid,
	output cpuBus_t bus
);

	regSel_t rdSelD;
	logic rdPend;
	lspcModeWord_u statusWord;
	logic [15:0] readMux;

	// Commands reach the VRAM stage in the same cycle
	assign bus = cpu;

	always_comb
	begin
		statusWord.rd.raster = status.raster;
		statusWord.rd.zeros = 3'b000;
		statusWord.rd.vmode = `LSPC_VMODE;
		statusWord.rd.aaCount = status.aaCount;
	end

	// Select is one cycle old here, lined up with the bank read
	always_comb
	begin
		case (rdSelD)
			REG_VRAMADDR, REG_VRAMRW: readMux = vramRead;
			REG_LSPCMODE: readMux = statusWord;
			REG_VRAMMOD: readMux = modulo;
			default: readMux = 16'h0000;
		endcase
	end

	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			rdPend <= 1'b0;
			rdValid <= 1'b0;
		end
		else
		begin
			rdPend <= cpu.rdEn;
			rdValid <= rdPend;
		end
	end

	always_ff @(posedge clk24M)
	begin
		rdSelD <= cpu.regSel;
		if (rdPend)
			rdData <= readMux;
	end

endmodule

`default_nettype wire

//--- lspc2.sv
// LSPC2 CPU-side top level
// Connects the CPU port, VRAM access, VRAM banks and raster timing
`timescale 1ns/1ns
`default_nettype none

module lspc2
	import lspcRegPkg::*, lspcVideoPkg::*;
(
	input wire logic clk24M,
	input wire logic reset,
	input wire cpuBus_t cpu,
	output logic [15:0] rdData,
	output logic rdValid
);

	cpuBus_t bus;
	vramCmd_t cmd;
	videoStatus_t status;
	logic [15:0] vramRead;
	logic [15:0] modulo;
	logic [7:0] aaSpeed;

	cpuPortDecode u_cpuPortDecode (
		.clk24M(clk24M),
		.reset(reset),
		.cpu(cpu),
		.status(status),
		.vramRead(vramRead),
		.modulo(modulo),
		.rdData(rdData),
		.rdValid(rdValid),
		.bus(bus)
	);

	vramAccess u_vramAccess (
		.clk24M(clk24M),
		.reset(reset),
		.bus(bus),
		.cmd(cmd),
		.modulo(modulo),
		.aaSpeed(aaSpeed)
	);

	vramBanks u_vramBanks (
		.clk24M(clk24M),
		.cmd(cmd),
		.vramRead(vramRead)
	);

	rasterTiming u_rasterTiming (
		.clk24M(clk24M),
		.reset(reset),
		.aaSpeed(aaSpeed),
		.status(status)
	);

endmodule

`default_nettype wire

//--- lspcRegPkg.sv
// LSPC register map and CPU-side types
// Holds the CPU port struct, the VRAM command and the mode register views
`default_nettype none

package lspcRegPkg;

	// Register select, CPU address bits 3:1
	typedef logic [2:0] regSel_t;

	typedef enum logic [2:0]
	{
		REG_VRAMADDR = 3'd0,
		REG_VRAMRW = 3'd1,
		REG_LSPCMODE = 3'd2,
		REG_VRAMMOD = 3'd3
	} regName_t;

	// One CPU command per cycle, strobes never both high
	typedef struct packed
	{
		regSel_t regSel;
		logic wrEn;
		logic rdEn;
		logic [15:0] wrData;
	} cpuBus_t;

	typedef struct packed
	{
		logic [15:0] addr;
		logic [15:0] data;
		logic wrEn;
	} vramCmd_t;

	// LSPCMODE as the CPU writes it
	typedef struct packed
	{
		logic [7:0] aaSpeed;
		logic [7:0] unused;
	} modeWrite_t;

	// LSPCMODE as the CPU reads it back
	typedef struct packed
	{
		logic [8:0] raster;
		logic [2:0] zeros;
		logic vmode;
		logic [2:0] aaCount;
	} modeRead_t;

	typedef union packed
	{
		modeWrite_t wr;
		modeRead_t rd;
	} lspcModeWord_u;

endpackage

`default_nettype wire

//--- lspcVideoPkg.sv
// Video-side types for the raster and auto-animation counters
`default_nettype none

package lspcVideoPkg;

	typedef logic [8:0] raster_t;
	typedef logic [8:0] pixel_t;

	// Auto-animation tile number
	typedef logic [2:0] aaCount_t;

	// What the timing block reports to the CPU port
	typedef struct packed
	{
		raster_t raster;
		aaCount_t aaCount;
	} videoStatus_t;

endpackage

`default_nettype wire

//--- lspc_defines.svh
// LSPC timing and memory size constants
// NTSC line timing only, raster runs 0x0F8 to 0x1FF
`ifndef LSPC_DEFINES_SVH
`define LSPC_DEFINES_SVH

// Pixel clocks in one raster line
`define LSPC_PIXELS_PER_LINE 384

// Raster range of one frame, 264 lines
`define LSPC_RASTER_FIRST 9'h0F8
`define LSPC_RASTER_LAST 9'h1FF

// Video mode reported in status, 0 is NTSC
`define LSPC_VMODE 1'b0

// VRAM bank sizes in 16-bit words
`define LSPC_SLOW_WORDS 32768
`define LSPC_FAST_WORDS 2048

`endif

//--- rasterTiming.sv
// Raster timing and auto-animation
// Pixel and line counters for NTSC, plus the frame countdown that steps
// the auto-animation tile number
`timescale 1ns/1ns
`default_nettype none
`include "lspc_defines.svh"

module rasterTiming
	import lspcVideoPkg::*;
(
	input wire logic clk24M,
	input wire logic reset,
	input wire logic [7:0] aaSpeed,
	output videoStatus_t status
);

	pixel_t pixel;
	raster_t raster;
	aaCount_t aaCount;
	logic [7:0] countdown;
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (pixel == pixel_t'(`LSPC_PIXELS_PER_LINE - 1));
	assign frameEnd = lineEnd && (raster == `LSPC_RASTER_LAST);

	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			pixel <= '0;
			raster <= `LSPC_RASTER_FIRST;
			aaCount <= '0;
			countdown <= 8'h00;
		end
		else
		begin
			pixel <= lineEnd ? '0 : pixel + 1'b1;
			if (lineEnd)
				raster <= (raster == `LSPC_RASTER_LAST) ? `LSPC_RASTER_FIRST : raster + 1'b1;
			// Countdown reload sets frames per tile step to aaSpeed + 1
			if (frameEnd)
			begin
				if (countdown == 8'h00)
				begin
					aaCount <= aaCount + 1'b1;
					countdown <= aaSpeed;
				end
				else
					countdown <= countdown - 1'b1;
			end
		end
	end

	assign status = '{raster: raster, aaCount: aaCount};

	pixelInLine: assert property (@(posedge clk24M) disable iff (reset)
		pixel < `LSPC_PIXELS_PER_LINE);

endmodule

`default_nettype wire

//--- tbLspc2.sv
// Testbench for the LSPC2 CPU-side top level
// Applies a table of register writes, reads and waits and checks the read data
`timescale 1ns/1ns
`default_nettype none
`include "lspc_defines.svh"

module tbLspc2
	import lspcRegPkg::*, lspcVideoPkg::*;
();

	typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_MARK, OP_WAIT, OP_LINES, OP_FRAMES} opKind_t;

	// Data holds the line count for waits and status deltas
	typedef struct packed
	{
		opKind_t op;
		regSel_t sel;
		logic [15:0] data;
		logic [15:0] expVal;
	} stimRow_t;

	localparam int FRAME_LINES = `LSPC_RASTER_LAST - `LSPC_RASTER_FIRST + 1;
	// About 12 frames against the 9 frames of waits
	localparam int TIMEOUT_CYCLES = 1200000;

	logic clk24M;
	logic reset;
	cpuBus_t cpu;
	logic [15:0] rdData;
	logic rdValid;
	stimRow_t rows [0:47];
	int rowCount;
	int cycles;
	logic [15:0] rnd [0:7];

	lspc2 u_lspc2 (
		.clk24M(clk24M),
		.reset(reset),
		.cpu(cpu),
		.rdData(rdData),
		.rdValid(rdValid)
	);

	initial
	begin
		clk24M = 1'b0;
		forever #5 clk24M = ~clk24M;
	end

	task automatic stopRun(input string msg);
		$display("Done: errors found");
		$fatal(1, "%s", msg);
	endtask

	always @(posedge clk24M)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			stopRun($sformatf("Timeout: the tests did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	task automatic nextCycle();
		@(posedge clk24M);
		#1;
	endtask

	task automatic reportError(input string msg);
		$display("error %0t: %s", $time, msg);
		stopRun("Stopped at the first mismatch");
	endtask

	task automatic checkWord(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp)
			reportError($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic checkStatus(input lspcModeWord_u got, input lspcModeWord_u exp);
		if (got.rd.raster !== exp.rd.raster)
			reportError($sformatf("raster got %h expected %h", got.rd.raster, exp.rd.raster));
		else if (got.rd.zeros !== exp.rd.zeros)
			reportError($sformatf("zero bits got %b expected %b", got.rd.zeros, exp.rd.zeros));
		else if (got.rd.vmode !== exp.rd.vmode)
			reportError($sformatf("vmode got %b expected %b", got.rd.vmode, exp.rd.vmode));
		else if (got.rd.aaCount !== exp.rd.aaCount)
			reportError($sformatf("aaCount got %0d expected %0d", got.rd.aaCount, exp.rd.aaCount));
	endtask

	// Write strobe for one cycle, then idle up to the 4-cycle spacing
	task automatic issueWrite(input regSel_t sel, input logic [15:0] data);
		cpu.regSel = sel;
		cpu.wrData = data;
		cpu.wrEn = 1'b1;
		nextCycle();
		cpu.wrEn = 1'b0;
		repeat (3) nextCycle();
	endtask

	// Always takes 4 cycles so that waits line up with the read strobes
	task automatic issueRead(input regSel_t sel, output logic [15:0] data);
		cpu.regSel = sel;
		cpu.rdEn = 1'b1;
		nextCycle();
		cpu.rdEn = 1'b0;
		if (rdValid !== 1'b0)
			stopRun($sformatf("rdValid came one cycle early after a read at %0t", $time));
		nextCycle();
		if (rdValid !== 1'b1)
			stopRun($sformatf("rdValid did not arrive two cycles after a read at %0t", $time));
		data = rdData;
		nextCycle();
		if (rdValid !== 1'b0)
			stopRun($sformatf("rdValid stayed high longer than one cycle at %0t", $time));
		nextCycle();
	endtask

	task automatic addRow(input opKind_t op, input regSel_t sel, input logic [15:0] data,
		input logic [15:0] expVal);
		rows[rowCount] = '{op: op, sel: sel, data: data, expVal: expVal};
		rowCount++;
	endtask

	task automatic buildTable();
		// Slow bank sequence with modulo 1, re-addressed before each read
		addRow(OP_WRITE, REG_VRAMMOD, 16'h0001, 16'h0);
		addRow(OP_WRITE, REG_VRAMADDR, 16'h0100, 16'h0);
		for (int i = 0; i < 4; i++)
			addRow(OP_WRITE, REG_VRAMRW, rnd[i], 16'h0);
		for (int i = 0; i < 4; i++)
		begin
			addRow(OP_WRITE, REG_VRAMADDR, 16'h0100 + 16'(i), 16'h0);
			addRow(OP_READ, REG_VRAMRW, 16'h0, rnd[i]);
		end
		// Fast and slow bank at the same low address bits with modulo 0x20
		addRow(OP_WRITE, REG_VRAMMOD, 16'h0020, 16'h0);
		addRow(OP_WRITE, REG_VRAMADDR, 16'h8010, 16'h0);
		addRow(OP_WRITE, REG_VRAMRW, rnd[4], 16'h0);
		addRow(OP_WRITE, REG_VRAMRW, rnd[5], 16'h0);
		addRow(OP_WRITE, REG_VRAMADDR, 16'h0010, 16'h0);
		addRow(OP_WRITE, REG_VRAMRW, rnd[6], 16'h0);
		addRow(OP_WRITE, REG_VRAMRW, rnd[7], 16'h0);
		addRow(OP_WRITE, REG_VRAMADDR, 16'h8010, 16'h0);
		addRow(OP_READ, REG_VRAMADDR, 16'h0, rnd[4]);
		addRow(OP_WRITE, REG_VRAMADDR, 16'h8030, 16'h0);
		addRow(OP_READ, REG_VRAMRW, 16'h0, rnd[5]);
		addRow(OP_WRITE, REG_VRAMADDR, 16'h0010, 16'h0);
		addRow(OP_READ, REG_VRAMADDR, 16'h0, rnd[6]);
		addRow(OP_WRITE, REG_VRAMADDR, 16'h0030, 16'h0);
		addRow(OP_READ, REG_VRAMRW, 16'h0, rnd[7]);
		// Modulo readback, an unused select and the status word
		addRow(OP_WRITE, REG_VRAMMOD, rnd[3] ^ rnd[0], 16'h0);
		addRow(OP_READ, REG_VRAMMOD, 16'h0, rnd[3] ^ rnd[0]);
		addRow(OP_READ, regSel_t'(3'd5), 16'h0, 16'h0000);
		addRow(OP_MARK, REG_LSPCMODE, 16'h0, 16'h0);
		addRow(OP_WAIT, REG_LSPCMODE, 16'd5, 16'h0);
		addRow(OP_LINES, REG_LSPCMODE, 16'd5, 16'h0);
		// Auto-animation at speed 0, then speed 1 after settling
		addRow(OP_MARK, REG_LSPCMODE, 16'h0, 16'h0);
		addRow(OP_WAIT, REG_LSPCMODE, 16'(3 * FRAME_LINES), 16'h0);
		addRow(OP_FRAMES, REG_LSPCMODE, 16'(3 * FRAME_LINES), 16'd3);
		addRow(OP_WRITE, REG_LSPCMODE, 16'h0100, 16'h0);
		addRow(OP_WAIT, REG_LSPCMODE, 16'(2 * FRAME_LINES), 16'h0);
		addRow(OP_MARK, REG_LSPCMODE, 16'h0, 16'h0);
		addRow(OP_WAIT, REG_LSPCMODE, 16'(4 * FRAME_LINES), 16'h0);
		addRow(OP_FRAMES, REG_LSPCMODE, 16'(4 * FRAME_LINES), 16'd2);
	endtask

	initial
	begin
		logic [15:0] word;
		lspcModeWord_u base;
		lspcModeWord_u exp;
		int total;
		reset = 1'b1;
		cpu = '0;
		cycles = 0;
		rowCount = 0;
		void'($urandom(32'h2be1));
		foreach (rnd[i])
			rnd[i] = 16'($urandom);
		buildTable();
		base = '0;
		repeat (8) @(posedge clk24M);
		#1;
		reset = 1'b0;
		repeat (2) nextCycle();
		if (rdValid !== 1'b0)
			reportError("rdValid high after reset");
		for (int r = 0; r < rowCount; r++)
		begin
			case (rows[r].op)
				OP_WRITE: issueWrite(rows[r].sel, rows[r].data);
				OP_READ:
				begin
					issueRead(rows[r].sel, word);
					checkWord(word, rows[r].expVal, $sformatf("row %0d read", r));
				end
				// Wait counts from the previous read strobe, which took 4 cycles
				OP_WAIT: repeat (int'(rows[r].data) * `LSPC_PIXELS_PER_LINE - 4) nextCycle();
				default:
				begin
					issueRead(REG_LSPCMODE, word);
					exp = lspcModeWord_u'(word);
					exp.rd.zeros = 3'b000;
					exp.rd.vmode = `LSPC_VMODE;
					if (rows[r].op != OP_MARK)
					begin
						total = int'(base.rd.raster - `LSPC_RASTER_FIRST) + int'(rows[r].data);
						exp.rd.raster = `LSPC_RASTER_FIRST + raster_t'(total % FRAME_LINES);
						// Speed 0 steps the tile once per frame wrap
						if (rows[r].op == OP_LINES)
							exp.rd.aaCount = base.rd.aaCount + aaCount_t'(total / FRAME_LINES);
						else
							exp.rd.aaCount = base.rd.aaCount + aaCount_t'(rows[r].expVal);
					end
					checkStatus(lspcModeWord_u'(word), exp);
					base = lspcModeWord_u'(word);
				end
			endcase
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
lspcRegPkg.sv
lspcVideoPkg.sv
cpuPortDecode.sv
vramAccess.sv
vramBanks.sv
rasterTiming.sv
lspc2.sv
tbLspc2.sv

//--- vramAccess.sv
// VRAM access stage
// Holds the address, modulo and write data registers, issues one write
// command after each VRAMRW write and then steps the address by the modulo
`timescale 1ns/1ns
`default_nettype none

module vramAccess
	import lspcRegPkg::*;
(
	input wire logic clk24M,
	input wire logic reset,
	input wire cpuBus_t bus,
	output vramCmd_t cmd,
	output logic [15:0] modulo,
	output logic [7:0] aaSpeed
);

	lspcModeWord_u modeWord;
	logic wrAddr;
	logic wrRw;
	logic wrMod;
	logic wrMode;
	logic [15:0] vramAddr;
	logic [15:0] writeData;
	logic writePending;

	// Write decode
	assign wrAddr = bus.wrEn && (bus.regSel == REG_VRAMADDR);
	assign wrRw = bus.wrEn && (bus.regSel == REG_VRAMRW);
	assign wrMod = bus.wrEn && (bus.regSel == REG_VRAMMOD);
	assign wrMode = bus.wrEn && (bus.regSel == REG_LSPCMODE);

	assign modeWord = lspcModeWord_u'(bus.wrData);

	always_ff @(posedge clk24M)
	begin
		if (reset)
		begin
			vramAddr <= 16'h0000;
			modulo <= 16'h0000;
			aaSpeed <= 8'h00;
			writePending <= 1'b0;
		end
		else
		begin
			writePending <= wrRw;
			// A new address wins over the auto-increment
			if (wrAddr)
				vramAddr <= bus.wrData;
			else if (writePending)
				vramAddr <= vramAddr + modulo;
			if (wrMod)
				modulo <= bus.wrData;
			if (wrMode)
				aaSpeed <= modeWord.wr.aaSpeed;
		end
	end

	always_ff @(posedge clk24M)
	begin
		if (wrRw)
			writeData <= bus.wrData;
	end

	// Bank reads follow the address register every cycle
	always_comb
	begin
		cmd.addr = vramAddr;
		cmd.data = writeData;
		cmd.wrEn = writePending;
	end

	noDualStrobe: assert property (@(posedge clk24M) disable iff (reset)
		!(bus.wrEn && bus.rdEn));

endmodule

`default_nettype wire

//--- vramBanks.sv
// Slow and fast VRAM banks
// Address bit 15 picks the bank, reads come back one cycle later
`timescale 1ns/1ns
`default_nettype none
`include "lspc_defines.svh"

module vramBanks
	import lspcRegPkg::*;
(
	input wire logic clk24M,
	input wire vramCmd_t cmd,
	output logic [15:0] vramRead
);

	logic [15:0] slowMem [0:`LSPC_SLOW_WORDS-1];
	logic [15:0] fastMem [0:`LSPC_FAST_WORDS-1];
	logic [15:0] slowRead;
	logic [15:0] fastRead;
	logic fastSel;

	always_ff @(posedge clk24M)
	begin
		if (cmd.wrEn && !cmd.addr[15])
			slowMem[cmd.addr[14:0]] <= cmd.data;
		slowRead <= slowMem[cmd.addr[14:0]];
	end

	// Fast bank only decodes the low 11 bits
	always_ff @(posedge clk24M)
	begin
		if (cmd.wrEn && cmd.addr[15])
			fastMem[cmd.addr[10:0]] <= cmd.data;
		fastRead <= fastMem[cmd.addr[10:0]];
	end

	always_ff @(posedge clk24M)
	begin
		fastSel <= cmd.addr[15];
	end

	assign vramRead = fastSel ? fastRead : slowRead;

	fastWriteInRange: assert property (@(posedge clk24M)
		(cmd.wrEn && cmd.addr[15]) |-> (cmd.addr[14:11] == 4'd0));

endmodule

`default_nettype wire
